// File: verilog/mem_bus_pkg.sv
package mem_bus_pkg;

    // address and data widths of the memory bus
    localparam int XLEN        = 32;
    localparam int LINE_BITS   = 64;
    localparam int OFFSET_BITS = 3;    // byte offset inside one 64-bit line

    // response / tag numbers, zero is reserved for "none"
    localparam int MEM_TAG_BITS = 4;
    localparam int NUM_MEM_TAGS = (1 << MEM_TAG_BITS) - 1;

    typedef logic [XLEN-1:0]         addr_t;
    typedef logic [LINE_BITS-1:0]    line_t;
    typedef logic [MEM_TAG_BITS-1:0] mem_tag_t;

    // bus command, same encoding the memory model expects
    typedef enum logic [1:0] {
        BUS_NONE  = 2'h0,
        BUS_LOAD  = 2'h1,
        BUS_STORE = 2'h2
    } bus_cmd_e;

endpackage

// File: verilog/cache_controller.sv
module cache_controller (
    input  logic                  clock,
    input  logic                  rst_n,

    // instruction cache requests
    input  mem_bus_pkg::bus_cmd_e ic_command,
    input  mem_bus_pkg::addr_t    ic_addr,

    // data cache requests
    input  mem_bus_pkg::bus_cmd_e dc_command,
    input  mem_bus_pkg::addr_t    dc_addr,
    input  mem_bus_pkg::line_t    dc_wdata,

    // memory answers
    input  mem_bus_pkg::mem_tag_t mem_response,
    input  mem_bus_pkg::line_t    mem_rdata,
    input  mem_bus_pkg::mem_tag_t mem_tag,

    // memory request
    output mem_bus_pkg::bus_cmd_e mem_command,
    output mem_bus_pkg::addr_t    mem_addr,
    output mem_bus_pkg::line_t    mem_wdata,

    output mem_bus_pkg::mem_tag_t ic_response,
    output mem_bus_pkg::line_t    ic_rdata,
    output mem_bus_pkg::mem_tag_t ic_tag,

    output mem_bus_pkg::mem_tag_t dc_response,
    output mem_bus_pkg::line_t    dc_rdata,
    output mem_bus_pkg::mem_tag_t dc_tag
);
    import mem_bus_pkg::*;

    logic                  d_request;
    logic                  load_accepted;
    logic                  tag_valid;    // returning tag belongs to a recorded load
    logic [NUM_MEM_TAGS:1] pending;      // one entry per response number
    logic [NUM_MEM_TAGS:1] owner_dc;     // 1 = data cache, 0 = instruction cache

    assign d_request     = (dc_command != BUS_NONE);
    assign load_accepted = (mem_command == BUS_LOAD) && (mem_response != '0);
    assign tag_valid     = (mem_tag != '0) && pending[mem_tag];

    // data cache wins whenever it has something on the bus
    always_comb begin
        if (d_request) begin
            mem_command = dc_command;
            mem_addr    = dc_addr;
            mem_wdata   = dc_wdata;
            dc_response = mem_response;
            ic_response = '0;    // icache sees a reject and retries
        end else begin
            mem_command = ic_command;
            mem_addr    = ic_addr;
            mem_wdata   = '0;
            dc_response = '0;
            ic_response = mem_response;
        end
    end

    // tags go to whoever got that number, independent of who requests now
    always_comb begin
        dc_tag   = '0;
        dc_rdata = '0;
        ic_tag   = '0;
        ic_rdata = '0;
        if (tag_valid) begin
            if (owner_dc[mem_tag]) begin
                dc_tag   = mem_tag;
                dc_rdata = mem_rdata;
            end else begin
                ic_tag   = mem_tag;
                ic_rdata = mem_rdata;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pending  <= '0;
            owner_dc <= '0;
        end else begin
            if (tag_valid)
                pending[mem_tag] <= 1'b0;
            // a new accept of the same number overrides the retire
            if (load_accepted) begin
                pending[mem_response]  <= 1'b1;
                owner_dc[mem_response] <= d_request;
            end
        end
    end

endmodule

// File: verilog/icache.sv
module icache #(
    parameter int ICACHE_LINES = 16
) (
    input  logic                  clock,
    input  logic                  rst_n,

    // fetch port
    input  logic                  fetch_req,
    input  mem_bus_pkg::addr_t    fetch_addr,
    output logic                  fetch_valid,
    output mem_bus_pkg::line_t    fetch_data,

    // controller side
    output mem_bus_pkg::bus_cmd_e ic_command,
    output mem_bus_pkg::addr_t    ic_addr,
    input  mem_bus_pkg::mem_tag_t ic_response,
    input  mem_bus_pkg::line_t    ic_rdata,
    input  mem_bus_pkg::mem_tag_t ic_tag
);
    import mem_bus_pkg::*;

    localparam int IDX_BITS = $clog2(ICACHE_LINES);
    localparam int TAG_BITS = XLEN - IDX_BITS - OFFSET_BITS;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] ltag_t;

    typedef enum logic [1:0] {
        IC_IDLE,
        IC_REQ,     // BUS_LOAD on the bus until accepted
        IC_WAIT     // waiting for our tag
    } ic_state_e;

    ic_state_e   state;

    line_t       data_mem [ICACHE_LINES];
    ltag_t       tag_mem  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] valid;

    addr_t       req_addr;    // address of the miss being serviced
    mem_tag_t    num_q;       // number memory gave to our load

    addr_t       look_addr;
    idx_t        look_idx;
    ltag_t       look_tag;
    logic        hit;
    logic        accepted;
    logic        fill_en;

    // new fetch looks up directly, a miss keeps looking at the held address
    assign look_addr = (state == IC_IDLE) ? fetch_addr : req_addr;
    assign look_idx  = look_addr[OFFSET_BITS +: IDX_BITS];
    assign look_tag  = look_addr[XLEN-1 -: TAG_BITS];
    assign hit       = valid[look_idx] && (tag_mem[look_idx] == look_tag);

    assign accepted = (state == IC_REQ) && (ic_response != '0);
    assign fill_en  = (state == IC_WAIT) && (ic_tag != '0) && (ic_tag == num_q);

    assign ic_command = (state == IC_REQ) ? BUS_LOAD : BUS_NONE;
    assign ic_addr    = {req_addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};  // line aligned

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IC_IDLE;
            valid       <= '0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= 1'b0;
            case (state)
                IC_IDLE: begin
                    if (fetch_req) begin
                        if (hit)
                            fetch_valid <= 1'b1;
                        else
                            state <= IC_REQ;
                    end
                end
                IC_REQ: begin
                    if (accepted)
                        state <= IC_WAIT;    // rejected: stay and retry
                end
                IC_WAIT: begin
                    if (fill_en) begin
                        valid[look_idx] <= 1'b1;
                        fetch_valid     <= 1'b1;
                        state           <= IC_IDLE;
                    end
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == IC_IDLE && fetch_req)
            req_addr <= fetch_addr;
        if (accepted)
            num_q <= ic_response;

        if (state == IC_IDLE && fetch_req && hit)
            fetch_data <= data_mem[look_idx];
        else if (fill_en)
            fetch_data <= ic_rdata;    // forward the fill straight out

        if (fill_en) begin
            data_mem[look_idx] <= ic_rdata;
            tag_mem[look_idx]  <= look_tag;
        end
    end

endmodule

// File: verilog/dcache.sv
module dcache #(
    parameter int DCACHE_LINES = 16
) (
    input  logic                  clock,
    input  logic                  rst_n,

    // processor data port
    input  logic                  data_load,
    input  logic                  data_store,
    input  mem_bus_pkg::addr_t    data_addr,
    input  mem_bus_pkg::line_t    data_wdata,
    output logic                  data_done,
    output mem_bus_pkg::line_t    data_rdata,

    // controller side
    output mem_bus_pkg::bus_cmd_e dc_command,
    output mem_bus_pkg::addr_t    dc_addr,
    output mem_bus_pkg::line_t    dc_wdata,
    input  mem_bus_pkg::mem_tag_t dc_response,
    input  mem_bus_pkg::line_t    dc_rdata,
    input  mem_bus_pkg::mem_tag_t dc_tag
);
    import mem_bus_pkg::*;

    localparam int IDX_BITS = $clog2(DCACHE_LINES);
    localparam int TAG_BITS = XLEN - IDX_BITS - OFFSET_BITS;

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [TAG_BITS-1:0] ltag_t;

    typedef enum logic [1:0] {
        DC_IDLE,
        DC_LOAD_REQ,
        DC_LOAD_WAIT,
        DC_STORE_REQ
    } dc_state_e;

    dc_state_e state;

    line_t     data_mem [DCACHE_LINES];
    ltag_t     tag_mem  [DCACHE_LINES];
    logic [DCACHE_LINES-1:0] valid;

    addr_t     req_addr;
    line_t     wdata_q;     // store data held while memory rejects
    mem_tag_t  num_q;

    addr_t     look_addr;
    idx_t      look_idx;
    ltag_t     look_tag;
    logic      hit;
    logic      load_hit;
    logic      load_acc;
    logic      store_acc;
    logic      fill_en;
    logic      upd_en;

    assign look_addr = (state == DC_IDLE) ? data_addr : req_addr;
    assign look_idx  = look_addr[OFFSET_BITS +: IDX_BITS];
    assign look_tag  = look_addr[XLEN-1 -: TAG_BITS];
    assign hit       = valid[look_idx] && (tag_mem[look_idx] == look_tag);

    assign load_hit  = (state == DC_IDLE) && data_load && hit;
    assign load_acc  = (state == DC_LOAD_REQ) && (dc_response != '0);
    assign store_acc = (state == DC_STORE_REQ) && (dc_response != '0);
    assign fill_en   = (state == DC_LOAD_WAIT) && (dc_tag != '0) && (dc_tag == num_q);
    assign upd_en    = store_acc && hit;    // write-through, no allocate on a store miss

    always_comb begin
        case (state)
            DC_LOAD_REQ:  dc_command = BUS_LOAD;
            DC_STORE_REQ: dc_command = BUS_STORE;
            default:      dc_command = BUS_NONE;
        endcase
    end

    assign dc_addr  = {req_addr[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign dc_wdata = wdata_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state     <= DC_IDLE;
            valid     <= '0;
            data_done <= 1'b0;
        end else begin
            data_done <= 1'b0;
            case (state)
                DC_IDLE: begin
                    if (data_load) begin    // load wins if both are raised
                        if (hit)
                            data_done <= 1'b1;
                        else
                            state <= DC_LOAD_REQ;
                    end else if (data_store) begin
                        state <= DC_STORE_REQ;
                    end
                end
                DC_LOAD_REQ: begin
                    if (load_acc)
                        state <= DC_LOAD_WAIT;
                end
                DC_LOAD_WAIT: begin
                    if (fill_en) begin
                        valid[look_idx] <= 1'b1;
                        data_done       <= 1'b1;
                        state           <= DC_IDLE;
                    end
                end
                DC_STORE_REQ: begin
                    // store is finished once memory takes it
                    if (store_acc) begin
                        data_done <= 1'b1;
                        state     <= DC_IDLE;
                    end
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == DC_IDLE && (data_load || data_store)) begin
            req_addr <= data_addr;
            wdata_q  <= data_wdata;
        end
        if (load_acc)
            num_q <= dc_response;

        if (load_hit)
            data_rdata <= data_mem[look_idx];
        else if (fill_en)
            data_rdata <= dc_rdata;

        if (fill_en) begin
            data_mem[look_idx] <= dc_rdata;
            tag_mem[look_idx]  <= look_tag;
        end else if (upd_en) begin
            data_mem[look_idx] <= wdata_q;    // keep cached copy in step with memory
        end
    end

endmodule

// File: verilog/mem_subsys_top.sv
module mem_subsys_top #(
    parameter int ICACHE_LINES = 16,
    parameter int DCACHE_LINES = 16
) (
    input  logic                  clock,
    input  logic                  rst_n,

    // instruction fetch
    input  logic                  fetch_req,
    input  mem_bus_pkg::addr_t    fetch_addr,
    output logic                  fetch_valid,
    output mem_bus_pkg::line_t    fetch_data,

    // data access
    input  logic                  data_load,
    input  logic                  data_store,
    input  mem_bus_pkg::addr_t    data_addr,
    input  mem_bus_pkg::line_t    data_wdata,
    output logic                  data_done,
    output mem_bus_pkg::line_t    data_rdata,

    // memory bus
    output mem_bus_pkg::bus_cmd_e mem_command,
    output mem_bus_pkg::addr_t    mem_addr,
    output mem_bus_pkg::line_t    mem_wdata,
    input  mem_bus_pkg::mem_tag_t mem_response,
    input  mem_bus_pkg::line_t    mem_rdata,
    input  mem_bus_pkg::mem_tag_t mem_tag
);
    import mem_bus_pkg::*;

    // icache <-> controller
    bus_cmd_e ic_command;
    addr_t    ic_addr;
    mem_tag_t ic_response;
    line_t    ic_rdata;
    mem_tag_t ic_tag;

    // dcache <-> controller
    bus_cmd_e dc_command;
    addr_t    dc_addr;
    line_t    dc_wdata;
    mem_tag_t dc_response;
    line_t    dc_rdata;
    mem_tag_t dc_tag;

    icache #(
        .ICACHE_LINES (ICACHE_LINES)
    ) u_icache (
        .clock       (clock),
        .rst_n       (rst_n),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_valid (fetch_valid),
        .fetch_data  (fetch_data),
        .ic_command  (ic_command),
        .ic_addr     (ic_addr),
        .ic_response (ic_response),
        .ic_rdata    (ic_rdata),
        .ic_tag      (ic_tag)
    );

    dcache #(
        .DCACHE_LINES (DCACHE_LINES)
    ) u_dcache (
        .clock       (clock),
        .rst_n       (rst_n),
        .data_load   (data_load),
        .data_store  (data_store),
        .data_addr   (data_addr),
        .data_wdata  (data_wdata),
        .data_done   (data_done),
        .data_rdata  (data_rdata),
        .dc_command  (dc_command),
        .dc_addr     (dc_addr),
        .dc_wdata    (dc_wdata),
        .dc_response (dc_response),
        .dc_rdata    (dc_rdata),
        .dc_tag      (dc_tag)
    );

    cache_controller u_ctrl (
        .clock        (clock),
        .rst_n        (rst_n),
        .ic_command   (ic_command),
        .ic_addr      (ic_addr),
        .dc_command   (dc_command),
        .dc_addr      (dc_addr),
        .dc_wdata     (dc_wdata),
        .mem_response (mem_response),
        .mem_rdata    (mem_rdata),
        .mem_tag      (mem_tag),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .ic_response  (ic_response),
        .ic_rdata     (ic_rdata),
        .ic_tag       (ic_tag),
        .dc_response  (dc_response),
        .dc_rdata     (dc_rdata),
        .dc_tag       (dc_tag)
    );

endmodule

// File: tests/tb_mem_subsys.sv
module tb_mem_subsys;
    import mem_bus_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int FIRST_LINES  = 8;     // lines touched by the first fetch pass
    localparam int MIX_OPS      = 24;    // ops per port in the mixed phase
    localparam int NUM_OPS      = 2 * FIRST_LINES + 14 + 2 * MIX_OPS;
    localparam int OP_CYCLES    = 40;    // one miss with rejects and a busy bus
    localparam int ANY  = 0;
    localparam int HIT  = 1;
    localparam int MISS = 2;

    logic     clock;
    logic     rst_n;
    logic     fetch_req;
    addr_t    fetch_addr;
    logic     fetch_valid;
    line_t    fetch_data;
    logic     data_load;
    logic     data_store;
    addr_t    data_addr;
    line_t    data_wdata;
    logic     data_done;
    line_t    data_rdata;
    bus_cmd_e mem_command;
    addr_t    mem_addr;
    line_t    mem_wdata;
    mem_tag_t mem_response = '0;
    line_t    mem_rdata    = '0;
    mem_tag_t mem_tag      = '0;

    // memory model state
    line_t       shadow [addr_t];    // only lines written by stores
    mem_tag_t    pend_num  [$];
    line_t       pend_data [$];
    int          pend_wait [$];
    mem_tag_t    next_num   = 4'd1;
    logic [15:0] lfsr_state = 16'd25;

    // operation under way on each port
    logic  f_busy     = 1'b0;
    addr_t f_addr     = '0;
    logic  d_busy     = 1'b0;
    logic  d_is_store = 1'b0;
    addr_t d_addr     = '0;
    line_t d_wdata    = '0;

    mem_subsys_top #(
        .ICACHE_LINES (16),
        .DCACHE_LINES (16)
    ) dut (.*);

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int b = 0; b < n; b++) begin
            v = (v << 1) | int'(lfsr_state[15]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    // power-up contents, every address bit changes the line
    function automatic line_t init_line(input addr_t la);
        return {la * 32'h9e37_79b9, la ^ 32'h5a5a_c3c3};
    endfunction

    // expected line: last stored value, else the power-up pattern
    function automatic line_t ref_line(input addr_t a);
        addr_t la;
        la = line_of(a);
        if (shadow.exists(la))
            return shadow[la];
        return init_line(la);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp)
            abort_run($sformatf("error %s: got %h expected %h", name, got, exp));
    endtask

    // bus request must belong to the fetch or data op in flight
    task automatic verify_request();
        logic d_match;
        logic f_match;
        if (mem_command == BUS_STORE) begin
            if (!(d_busy && d_is_store))
                abort_run("a store appeared on the bus while no store was in progress");
            compare_value("mem_addr", 64'(mem_addr), 64'(line_of(d_addr)));
            compare_value("mem_wdata", mem_wdata, d_wdata);
        end else begin
            compare_value("mem_command", 64'(mem_command), 64'(BUS_LOAD));
            d_match = d_busy && !d_is_store && (mem_addr == line_of(d_addr));
            f_match = f_busy && (mem_addr == line_of(f_addr));
            if (!d_match && !f_match)
                abort_run($sformatf("error mem_addr: got %h expected %h or %h",
                                    mem_addr, line_of(d_addr), line_of(f_addr)));
        end
    endtask

    // memory model, answers on the falling edge while the command is stable
    always @(negedge clock) begin
        int    hit_k;
        addr_t la;
        mem_tag      = '0;
        mem_rdata    = '0;
        mem_response = '0;
        if (rst_n) begin
            hit_k = -1;
            for (int k = 0; k < pend_num.size(); k++) begin
                pend_wait[k] = pend_wait[k] - 1;
                if (pend_wait[k] <= 0 && hit_k < 0)
                    hit_k = k;
            end
            if (hit_k >= 0) begin    // one tag per cycle, others wait longer
                mem_tag   = pend_num[hit_k];
                mem_rdata = pend_data[hit_k];
                pend_num.delete(hit_k);
                pend_data.delete(hit_k);
                pend_wait.delete(hit_k);
            end
            if (mem_command != BUS_NONE) begin
                verify_request();
                if (take_bits(1) == 0) begin
                    mem_response = next_num;
                    la = line_of(mem_addr);
                    if (mem_command == BUS_STORE) begin
                        shadow[la] = mem_wdata;
                    end else begin
                        pend_num.push_back(next_num);
                        pend_data.push_back(ref_line(la));
                        pend_wait.push_back(3 + take_bits(3));    // 3 to 10 cycles
                    end
                    next_num = (next_num == 4'd15) ? 4'd1 : next_num + 4'd1;
                end
            end
        end
    end

    // compare returned data against the reference
    always @(negedge clock) begin
        if (rst_n && fetch_valid)
            compare_value("fetch_data", fetch_data, ref_line(f_addr));
        if (rst_n && data_done && !d_is_store)
            compare_value("data_rdata", data_rdata, ref_line(d_addr));
    end

    task automatic fetch_line(input addr_t a, input int expect_kind);
        int cycles;
        cycles = 0;
        @(negedge clock);
        fetch_req  = 1'b1;
        fetch_addr = a;
        f_addr     = a;
        f_busy     = 1'b1;
        do begin
            @(negedge clock);
            fetch_req = 1'b0;
            cycles++;
        end while (!fetch_valid);
        f_busy = 1'b0;
        if (expect_kind == HIT)
            compare_value("fetch_cycles", 64'(cycles), 64'd1);
        else if (expect_kind == MISS && cycles <= 1)
            abort_run($sformatf("fetch of %h hit although a miss was expected", a));
    endtask

    task automatic access_data(input logic is_store, input addr_t a, input line_t wd,
                               input int expect_kind);
        int cycles;
        cycles = 0;
        @(negedge clock);
        data_load  = !is_store;
        data_store = is_store;
        data_addr  = a;
        data_wdata = wd;
        d_addr     = a;
        d_is_store = is_store;
        d_wdata    = wd;
        d_busy     = 1'b1;
        do begin
            @(negedge clock);
            data_load  = 1'b0;
            data_store = 1'b0;
            cycles++;
        end while (!data_done);
        d_busy = 1'b0;
        if (expect_kind == HIT)
            compare_value("data_cycles", 64'(cycles), 64'd1);
        else if (expect_kind == MISS && cycles <= 1)
            abort_run($sformatf("load of %h hit although a miss was expected", a));
    endtask

    initial begin
        #((RESET_CYCLES + 8 + NUM_OPS * OP_CYCLES + 100) * CLK_PERIOD);
        abort_run("timeout: the operations did not finish in time");
    end

    initial begin
        clock      = 1'b0;
        rst_n      = 1'b0;
        fetch_req  = 1'b0;
        fetch_addr = '0;
        data_load  = 1'b0;
        data_store = 1'b0;
        data_addr  = '0;
        data_wdata = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;

        // idle bus, no stray pulses
        repeat (8) begin
            @(negedge clock);
            compare_value("mem_command", 64'(mem_command), 64'(BUS_NONE));
            compare_value("fetch_valid", 64'(fetch_valid), 64'd0);
            compare_value("data_done", 64'(data_done), 64'd0);
        end

        for (int i = 0; i < FIRST_LINES; i++)
            fetch_line(32'h1000 + 32'(i * 8), MISS);
        for (int i = 0; i < FIRST_LINES; i++)
            fetch_line(32'h1000 + 32'(i * 8), HIT);

        // store to a cached line, then to an uncached one
        access_data(1'b0, 32'h8040, '0, MISS);
        access_data(1'b1, 32'h8040, 64'hdead_beef_0123_4567, ANY);
        compare_value("shadow", ref_line(32'h8040), 64'hdead_beef_0123_4567);
        access_data(1'b0, 32'h8040, '0, HIT);
        access_data(1'b1, 32'h8300, 64'h0f0f_1234_abcd_9876, ANY);
        compare_value("shadow", ref_line(32'h8300), 64'h0f0f_1234_abcd_9876);
        access_data(1'b0, 32'h8300, '0, MISS);    // no write-allocate

        // same index, different tags
        repeat (2) begin
            fetch_line(32'h1080, MISS);
            fetch_line(32'h1000, MISS);
        end
        repeat (2) begin
            access_data(1'b0, 32'h8480, '0, MISS);
            access_data(1'b0, 32'h8400, '0, MISS);
        end

        // both ports at once, tags return out of order
        fork
            begin
                for (int i = 0; i < MIX_OPS; i++)
                    fetch_line(32'h1000 + 32'(((i * 5) % 24) * 8), ANY);
            end
            begin
                for (int i = 0; i < MIX_OPS; i++)
                    access_data(i % 3 == 1, 32'h8000 + 32'(((i * 7) % 20) * 8),
                                {32'(i), ~32'(i)}, ANY);
            end
        join

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: mem_subsys.f
verilog/mem_bus_pkg.sv
verilog/cache_controller.sv
verilog/icache.sv
verilog/dcache.sv
verilog/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# builds the memory subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f mem_subsys.f --top-module tb_mem_subsys > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/Vtb_mem_subsys > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0
